//--- src/fpmul_cfg.svh
/* Multiplier configuration */
`ifndef FPMUL_CFG_SVH
`define FPMUL_CFG_SVH

// Signed internal exponent that is wide enough for a sum of two exponents
`define FP_EXP_W 10

// Mantissa with the hidden bit, and the product with two guard bits below it
`define FP_MANT_W 24
`define FP_PROD_W 50

`define FP_TAG_W 8

`define FP_BIAS 127
`define FP_EMIN (-126)
`define FP_QNAN 32'h7fc00000

`endif

//--- src/fp_format_pkg.sv
/* Number formats */
`include "fpmul_cfg.svh"

package fp_format_pkg;

  // Field view of an IEEE single word
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp_fields_t;

  // One word read either as raw bits or as its fields
  typedef union packed {
    logic [31:0] raw;
    fp_fields_t  f;
  } fp_word_t;

  // Unpacked number with an unbiased exponent and the hidden bit made explicit
  typedef struct packed {
    logic                        sign;
    logic signed [`FP_EXP_W-1:0] exp;
    logic [`FP_MANT_W-1:0]       mant;
  } fp_num_t;

  typedef logic [`FP_PROD_W-1:0] fp_prod_t;

endpackage

//--- src/fp_pipe_pkg.sv
/* Pipeline sideband */
`include "fpmul_cfg.svh"

package fp_pipe_pkg;

  typedef logic [`FP_TAG_W-1:0] fp_tag_t;

  // An idle item already holds its final result word
  typedef enum logic {
    no_idle  = 1'b0,
    put_idle = 1'b1
  } fp_idle_t;

endpackage

//--- src/fp_stage_if.sv
/* Stage-to-stage link */
`timescale 1ns/1ps

interface fp_stage_if
  import fp_format_pkg::*, fp_pipe_pkg::*;
();

  // An item is present whenever valid is high with no handshake
  logic     valid;
  fp_tag_t  tag;
  fp_idle_t idle;
  fp_num_t  z;
  fp_prod_t product;

  // Final word for idle items
  fp_word_t result;

  modport producer (
    output valid,
    output tag,
    output idle,
    output z,
    output product,
    output result
  );

  modport consumer (
    input valid,
    input tag,
    input idle,
    input z,
    input product,
    input result
  );

endinterface

//--- src/fp_unpack.sv
/* Operand unpack stage */
`timescale 1ns/1ps
`include "fpmul_cfg.svh"

module fp_unpack
  import fp_format_pkg::*, fp_pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  fp_word_t     a,
  input  fp_word_t     b,
  input  logic         in_valid,
  input  fp_tag_t      in_tag,
  fp_stage_if.producer down
);

  logic     a_nan, b_nan;
  logic     a_inf, b_inf;
  logic     a_zero, b_zero;
  fp_word_t special;
  fp_idle_t idle_next;
  fp_num_t  a_num;
  fp_num_t  b_num;

  always_comb begin
    a_nan  = (a.f.exp == 8'hff) && (a.f.frac != '0);
    b_nan  = (b.f.exp == 8'hff) && (b.f.frac != '0);
    a_inf  = (a.f.exp == 8'hff) && (a.f.frac == '0);
    b_inf  = (b.f.exp == 8'hff) && (b.f.frac == '0);
    // Subnormal operands count as zero
    a_zero = (a.f.exp == 8'h00);
    b_zero = (b.f.exp == 8'h00);

    special.raw    = '0;
    special.f.sign = a.f.sign ^ b.f.sign;
    idle_next      = put_idle;
    if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
      special.raw = `FP_QNAN;
    end else if (a_inf || b_inf) begin
      special.f.exp = 8'hff;
    end else if (!(a_zero || b_zero)) begin
      idle_next = no_idle;
    end

    a_num.sign = a.f.sign;
    a_num.exp  = `FP_EXP_W'(a.f.exp) - `FP_EXP_W'(`FP_BIAS);
    a_num.mant = {1'b1, a.f.frac};
    b_num.sign = b.f.sign;
    b_num.exp  = `FP_EXP_W'(b.f.exp) - `FP_EXP_W'(`FP_BIAS);
    b_num.mant = {1'b1, b.f.frac};
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= in_valid;
    end
  end

  // Operand a rides in the low bits of the product field
  always_ff @(posedge clock) begin
    down.tag     <= in_tag;
    down.idle    <= idle_next;
    down.result  <= special;
    down.z       <= b_num;
    down.product <= {{(`FP_PROD_W - $bits(fp_num_t)){1'b0}}, a_num};
  end

endmodule

//--- src/fp_product.sv
/* Exponent add and mantissa multiply */
`timescale 1ns/1ps
`include "fpmul_cfg.svh"

module fp_product
  import fp_format_pkg::*, fp_pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  fp_stage_if.consumer up,
  fp_stage_if.producer down
);

  fp_num_t                 a_num;
  fp_num_t                 prod_num;
  logic [2*`FP_MANT_W-1:0] mant_prod;

  always_comb begin
    a_num     = up.product[$bits(fp_num_t)-1:0];
    mant_prod = a_num.mant * up.z.mant;

    // The extra one puts the product's weight at bit 49
    prod_num.sign = a_num.sign ^ up.z.sign;
    prod_num.exp  = a_num.exp + up.z.exp + `FP_EXP_W'(1);
    prod_num.mant = mant_prod[2*`FP_MANT_W-1 -: `FP_MANT_W];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clock) begin
    down.tag    <= up.tag;
    down.idle   <= up.idle;
    down.result <= up.result;
    if (up.idle == put_idle) begin
      down.z <= up.z;
    end else begin
      down.z       <= prod_num;
      down.product <= {mant_prod, {(`FP_PROD_W - 2*`FP_MANT_W){1'b0}}};
    end
  end

endmodule

//--- src/fp_normalise_prod.sv
/* Product normalisation */
`timescale 1ns/1ps
`include "fpmul_cfg.svh"

module fp_normalise_prod
  import fp_format_pkg::*;
  import fp_pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  fp_stage_if.consumer up,
  fp_stage_if.producer down
);

  logic [`FP_EXP_W-1:0] shift;
  fp_prod_t             shift_mask;
  fp_prod_t             prod_next;
  fp_num_t              z_next;

  always_comb begin
    shift      = `FP_EXP_W'(`FP_EMIN) - up.z.exp;
    shift_mask = ~({`FP_PROD_W{1'b1}} << shift);
    z_next     = up.z;
    prod_next  = up.product;

    if ($signed(up.z.exp) < `FP_EMIN) begin
      // Denormalise onto FP_EMIN and keep the bits shifted out as sticky
      prod_next    = up.product >> shift;
      prod_next[0] = prod_next[0] | (|(up.product & shift_mask));
      z_next.exp   = `FP_EXP_W'(`FP_EMIN);
    end else if (!up.product[`FP_PROD_W-1]) begin
      prod_next  = up.product << 1;
      z_next.exp = up.z.exp - `FP_EXP_W'(1);
    end

    z_next.mant = prod_next[`FP_PROD_W-1 -: `FP_MANT_W];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  // Idle items pass z and leave the product register as it was
  always_ff @(posedge clock) begin
    down.tag    <= up.tag;
    down.idle   <= up.idle;
    down.result <= up.result;
    if (up.idle == put_idle) begin
      down.z <= up.z;
    end else begin
      down.z       <= z_next;
      down.product <= prod_next;
    end
  end

endmodule

//--- src/fp_round_pack.sv
/* Round and pack */
`timescale 1ns/1ps
`include "fpmul_cfg.svh"

module fp_round_pack
  import fp_format_pkg::*, fp_pipe_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  fp_stage_if.consumer up,
  output fp_word_t     result,
  output logic         out_valid,
  output fp_tag_t      out_tag
);

  fp_prod_t                    frac_all;
  logic                        low_bit;
  logic [`FP_MANT_W-1:0]       mant;
  logic                        guard, sticky, round_up;
  logic [`FP_MANT_W:0]         mant_sum;
  logic [`FP_MANT_W-1:0]       mant_r;
  logic signed [`FP_EXP_W-1:0] exp_eff, exp_r, biased;
  fp_word_t                    packed_w;

  always_comb begin
    frac_all = {up.z.mant, up.product[`FP_PROD_W-`FP_MANT_W-1:0]};
    exp_eff  = up.z.exp;
    low_bit  = frac_all[0];
    // A left shift taken at FP_EMIN lands one below it, so undo it here
    if ($signed(up.z.exp) < `FP_EMIN) begin
      frac_all    = frac_all >> 1;
      frac_all[0] = frac_all[0] | low_bit;
      exp_eff     = `FP_EXP_W'(`FP_EMIN);
    end

    mant     = frac_all[`FP_PROD_W-1 -: `FP_MANT_W];
    guard    = frac_all[`FP_PROD_W-`FP_MANT_W-1];
    sticky   = |frac_all[`FP_PROD_W-`FP_MANT_W-2:0];
    round_up = guard && (sticky || mant[0]);
    mant_sum = {1'b0, mant} + (`FP_MANT_W+1)'(round_up);

    if (mant_sum[`FP_MANT_W]) begin
      mant_r = mant_sum[`FP_MANT_W:1];
      exp_r  = exp_eff + `FP_EXP_W'(1);
    end else begin
      mant_r = mant_sum[`FP_MANT_W-1:0];
      exp_r  = exp_eff;
    end
    biased = exp_r + `FP_EXP_W'(`FP_BIAS);

    packed_w.f.sign = up.z.sign;
    packed_w.f.frac = mant_r[`FP_MANT_W-2:0];
    packed_w.f.exp  = biased[7:0];
    if (biased > 2*`FP_BIAS) begin
      packed_w.f.exp  = 8'hff;
      packed_w.f.frac = '0;
    end else if (exp_r == `FP_EMIN && !mant_r[`FP_MANT_W-1]) begin
      // Subnormal or zero
      packed_w.f.exp = 8'h00;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= up.valid;
    end
  end

  always_ff @(posedge clock) begin
    out_tag    <= up.tag;
    result.raw <= (up.idle == put_idle) ? up.result.raw : packed_w.raw;
  end

endmodule

//--- src/fp_mult_top.sv
/* Pipelined FP multiplier */
`timescale 1ns/1ps

module fp_mult_top
  import fp_format_pkg::*, fp_pipe_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  fp_word_t a,
  input  fp_word_t b,
  input  logic     in_valid,
  input  fp_tag_t  in_tag,
  output fp_word_t result,
  output logic     out_valid,
  output fp_tag_t  out_tag
);

  fp_stage_if unpack_if ();
  fp_stage_if product_if ();
  fp_stage_if norm_if ();

  fp_unpack u_unpack (
    .clock    (clock),
    .reset    (reset),
    .a        (a),
    .b        (b),
    .in_valid (in_valid),
    .in_tag   (in_tag),
    .down     (unpack_if.producer)
  );

  fp_product u_product (
    .clock (clock),
    .reset (reset),
    .up    (unpack_if.consumer),
    .down  (product_if.producer)
  );

  fp_normalise_prod u_normalise (
    .clock (clock),
    .reset (reset),
    .up    (product_if.consumer),
    .down  (norm_if.producer)
  );

  fp_round_pack u_round_pack (
    .clock     (clock),
    .reset     (reset),
    .up        (norm_if.consumer),
    .result    (result),
    .out_valid (out_valid),
    .out_tag   (out_tag)
  );

endmodule

//--- dv/fp_mult_properties.sv
/* Normalise stage assertions */
`timescale 1ns/1ps
`include "fpmul_cfg.svh"

module fp_mult_properties
  import fp_format_pkg::*, fp_pipe_pkg::*;
(
  input logic                        clock,
  input logic                        reset,
  input logic                        up_valid,
  input fp_tag_t                     up_tag,
  input fp_idle_t                    up_idle,
  input logic signed [`FP_EXP_W-1:0] up_exp,
  input fp_prod_t                    up_product,
  input logic                        down_valid,
  input fp_tag_t                     down_tag,
  input fp_idle_t                    down_idle,
  input logic signed [`FP_EXP_W-1:0] down_exp,
  input fp_prod_t                    down_product
);

  int       fail_count = 0;
  logic     active;
  logic     below_emin;
  int       gap;
  fp_prod_t denorm;
  logic     lost;

  // Expected right shift onto FP_EMIN with lost bits found by shifting back
  always_comb begin
    active     = up_valid && (up_idle == no_idle);
    below_emin = int'(up_exp) < `FP_EMIN;
    gap        = below_emin ? (`FP_EMIN - int'(up_exp)) : 0;
    denorm     = up_product >> gap;
    lost       = (denorm << gap) != up_product;
  end

  assert property (@(posedge clock) disable iff (reset)
    (active && below_emin) |=>
      (int'(down_exp) == `FP_EMIN) &&
      (down_product[`FP_PROD_W-1:1] == $past(denorm[`FP_PROD_W-1:1])) &&
      (down_product[0] == $past(denorm[0] | lost)))
  else begin
    $error("Denormalise branch gave a wrong product or exponent");
    fail_count++;
  end

  assert property (@(posedge clock) disable iff (reset)
    (active && !below_emin && !up_product[`FP_PROD_W-1]) |=>
      (down_product == $past(up_product << 1)) &&
      (int'(down_exp) == $past(int'(up_exp)) - 1))
  else begin
    $error("Left shift branch gave a wrong product or exponent");
    fail_count++;
  end

  assert property (@(posedge clock) disable iff (reset)
    (active && !below_emin && up_product[`FP_PROD_W-1]) |=>
      (down_product == $past(up_product)) && (down_exp == $past(up_exp)))
  else begin
    $error("Unshifted branch changed the product or exponent");
    fail_count++;
  end

  assert property (@(posedge clock) disable iff (reset)
    1'b1 |=> (down_valid == $past(up_valid)))
  else begin
    $error("Valid did not pass through in one cycle");
    fail_count++;
  end

  assert property (@(posedge clock) disable iff (reset)
    up_valid |=> (down_tag == $past(up_tag)) && (down_idle == $past(up_idle)))
  else begin
    $error("Tag or idle marker did not pass through");
    fail_count++;
  end

  // Idle items leave the product register alone
  assert property (@(posedge clock) disable iff (reset)
    (up_valid && up_idle == put_idle) |=> (down_product == $past(down_product)))
  else begin
    $error("Idle item changed the product register");
    fail_count++;
  end

endmodule

//--- dv/fp_mult_tb.sv
/* FP multiplier testbench */
`timescale 1ns/1ps
`include "fpmul_cfg.svh"

module fp_mult_tb
  import fp_format_pkg::*, fp_pipe_pkg::*;
();

  localparam int NUM_ITEMS      = 600;
  localparam int TIMEOUT_CYCLES = NUM_ITEMS + 50;

  typedef struct packed {
    logic [31:0] result;
    fp_tag_t     tag;
    int          due;
  } expect_t;

  logic        clock;
  logic        reset;
  fp_word_t    a;
  fp_word_t    b;
  logic        in_valid;
  fp_tag_t     in_tag;
  fp_word_t    result;
  logic        out_valid;
  fp_tag_t     out_tag;

  expect_t     expected_q[$];
  int          cycle = 0;
  int          sent = 0;
  int          value_errors = 0;
  int          seq_errors = 0;
  fp_tag_t     next_tag = '0;
  logic [31:0] rng_state = 32'h3fbd9fc5;

  fp_mult_top dut (
    .clock     (clock),
    .reset     (reset),
    .a         (a),
    .b         (b),
    .in_valid  (in_valid),
    .in_tag    (in_tag),
    .result    (result),
    .out_valid (out_valid),
    .out_tag   (out_tag)
  );

  bind fp_normalise_prod fp_mult_properties props (
    .clock        (clock),
    .reset        (reset),
    .up_valid     (up.valid),
    .up_tag       (up.tag),
    .up_idle      (up.idle),
    .up_exp       (up.z.exp),
    .up_product   (up.product),
    .down_valid   (down.valid),
    .down_tag     (down.tag),
    .down_idle    (down.idle),
    .down_exp     (down.z.exp),
    .down_product (down.product)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // IEEE single multiply with round to nearest even and subnormal operands read as zero
  function automatic logic [31:0] model_mul(input logic [31:0] x, input logic [31:0] y);
    logic        sign;
    int          ex;
    int          ey;
    logic [47:0] p;
    logic [63:0] p64;
    logic [63:0] kept;
    int          lead;
    int          be;
    int          sh;
    logic        guard;
    logic        sticky;
    sign = x[31] ^ y[31];
    ex   = int'(x[30:23]);
    ey   = int'(y[30:23]);
    if ((ex == 255 && x[22:0] != 0) || (ey == 255 && y[22:0] != 0)) begin
      return `FP_QNAN;
    end
    if ((ex == 255 && ey == 0) || (ey == 255 && ex == 0)) begin
      return `FP_QNAN;
    end
    if (ex == 255 || ey == 255) begin
      return {sign, 8'hff, 23'h0};
    end
    if (ex == 0 || ey == 0) begin
      return {sign, 31'h0};
    end
    // The product is worth p * 2^(ex + ey - 300)
    p    = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
    p64  = {16'h0, p};
    lead = p[47] ? 47 : 46;
    be   = ex + ey - 300 + lead + 127;
    // Keep the leading one and 23 bits below it, or bits down to 2^-149 when subnormal
    sh   = (be >= 1) ? (lead - 23) : (151 - ex - ey);
    if (sh > 60) begin
      sh = 60;
    end
    kept   = p64 >> sh;
    guard  = p64[sh-1];
    sticky = (p64 & ((64'h1 << (sh - 1)) - 64'h1)) != 0;
    if (guard && (sticky || kept[0])) begin
      kept = kept + 64'h1;
    end
    if (be < 1) begin
      return {sign, kept[30:0]};
    end
    if (kept[24]) begin
      kept = kept >> 1;
      be   = be + 1;
    end
    if (be > 254) begin
      return {sign, 8'hff, 23'h0};
    end
    return {sign, be[7:0], kept[22:0]};
  endfunction

  // Random word with its exponent field forced into [lo, lo + span)
  function automatic logic [31:0] shape(input logic [31:0] r, input int lo, input int span);
    int e;
    e = lo + (int'(r[30:23]) % span);
    return {r[31], e[7:0], r[22:0]};
  endfunction

  function automatic logic [31:0] special_word(input logic [2:0] idx);
    case (idx)
      3'd0:    return 32'h00000000;
      3'd1:    return 32'h80000000;
      3'd2:    return 32'h00000001;
      3'd3:    return 32'h807fffff;
      3'd4:    return 32'h7f800000;
      3'd5:    return 32'hff800000;
      3'd6:    return 32'h7fc00000;
      default: return 32'hffa00001;
    endcase
  endfunction

  task automatic next_random(output logic [31:0] w);
    rng_state = xorshift(rng_state);
    w = rng_state;
  endtask

  task automatic send(input logic [31:0] x, input logic [31:0] y);
    expect_t item;
    @(posedge clock);
    #1;
    a.raw    = x;
    b.raw    = y;
    in_valid = 1'b1;
    in_tag   = next_tag;
    item.result = model_mul(x, y);
    item.tag    = next_tag;
    item.due    = cycle + 4;
    expected_q.push_back(item);
    next_tag = next_tag + 1'b1;
    sent++;
  endtask

  task automatic idle_cycle();
    @(posedge clock);
    #1;
    in_valid = 1'b0;
  endtask

  // Outputs are checked at the falling edge between register updates
  always @(negedge clock) begin
    expect_t head;
    if (reset) begin
      assert (out_valid === 1'b0) else begin
        seq_errors++;
        $display("[ERROR] %0t: out_valid expected 0, got %b", $time, out_valid);
      end
    end else if (expected_q.size() != 0 && expected_q[0].due == cycle) begin
      head = expected_q.pop_front();
      assert (out_valid === 1'b1) else begin
        seq_errors++;
        $display("Missing output: no result for tag %0d at time %0t", head.tag, $time);
      end
      if (out_valid === 1'b1) begin
        assert (out_tag === head.tag) else begin
          value_errors++;
          $display("[ERROR] %0t: out_tag expected %0d, got %0d", $time, head.tag, out_tag);
        end
        assert (result.raw === head.result) else begin
          value_errors++;
          $display("[ERROR] %0t: result expected %h, got %h (tag %0d)",
                   $time, head.result, result.raw, head.tag);
        end
      end
    end else begin
      assert (out_valid === 1'b0) else begin
        seq_errors++;
        $display("Unexpected output: out_valid high at time %0t with no item due", $time);
      end
    end
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout: run passed %0d cycles with %0d results outstanding",
             TIMEOUT_CYCLES, expected_q.size());
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] sel;
    int          total;
    reset    = 1'b1;
    a.raw    = '0;
    b.raw    = '0;
    in_valid = 1'b0;
    in_tag   = '0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    idle_cycle();

    // No shift and one-bit left shift in stage 3
    send(32'h3fc00000, 32'h3fc00000);
    send(32'h3f800000, 32'h3f800000);
    send(32'hc0400000, 32'h40a00000);
    // Ties to even and mantissa carry-out
    send(32'h3f800001, 32'h3fc00000);
    send(32'h3f800003, 32'h3fc00000);
    send(32'h3ffffffe, 32'h3f800001);
    send(32'h00ffffff, 32'h3f000000);
    // Subnormal results and underflow to zero
    send(32'h00800000, 32'h3f000000);
    send(32'h00c00000, 32'h3f000000);
    send(32'h1f800000, 32'h1f800000);
    send(32'h00800000, 32'h00800000);
    send(32'h80800000, 32'h34000000);
    send(32'h00800000, 32'h33800000);
    send(32'h00c00000, 32'h33800000);
    // Overflow
    send(32'h7f000000, 32'h40400000);
    send(32'hff7fffff, 32'h3f800001);
    send(32'h7f7fffff, 32'h3f7fffff);
    // Special operands
    send(32'h00000000, 32'h3f800000);
    send(32'h80000000, 32'h40000000);
    send(32'h00000001, 32'h3f800000);
    send(32'h7f800000, 32'h3f800000);
    send(32'h7f800000, 32'hff800000);
    send(32'h7f800000, 32'h00000000);
    send(32'h80000000, 32'hff800000);
    send(32'h007fffff, 32'h7f800000);
    send(32'h7fc00000, 32'h3f800000);
    send(32'h3f800000, 32'hff800001);
    send(32'h7f800001, 32'h7f800000);
    idle_cycle();

    while (sent < NUM_ITEMS) begin
      next_random(r1);
      next_random(r2);
      next_random(sel);
      case (sel[2:0])
        3'd0:          send(r1, r2);
        3'd1, 3'd2, 3'd3: send(shape(r1, 112, 31), shape(r2, 112, 31));
        3'd4:          send(shape(r1, 1, 64), shape(r2, 40, 61));
        3'd5:          send(shape(r1, 190, 65), shape(r2, 150, 105));
        3'd6: begin
          if (sel[3]) begin
            send(special_word(sel[6:4]), shape(r1, 100, 55));
          end else begin
            send(shape(r1, 100, 55), special_word(sel[6:4]));
          end
        end
        // Short mantissas make exact halfway products common
        default: send(shape(r1 & 32'hfffff800, 112, 31), shape(r2 & 32'hfffff000, 112, 31));
      endcase
    end
    idle_cycle();

    while (expected_q.size() != 0) @(posedge clock);
    @(posedge clock);

    total = value_errors + seq_errors + dut.u_normalise.props.fail_count;
    $display("Errors: %0d value, %0d sequence, %0d assertion",
             value_errors, seq_errors, dut.u_normalise.props.fail_count);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/fp_format_pkg.sv
src/fp_pipe_pkg.sv
src/fp_stage_if.sv
src/fp_unpack.sv
src/fp_product.sv
src/fp_normalise_prod.sv
src/fp_round_pack.sv
src/fp_mult_top.sv
dv/fp_mult_properties.sv
dv/fp_mult_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the FP multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module fp_mult_tb -o fp_mult_sim

output=$(./obj_dir/fp_mult_sim)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx 'All tests passed'
